/* exe_unit.f */
+incdir+.
exe_unit_pkg.sv
prefix_adder.sv
barrel_shifter.sv
alu.sv
exe_datapath.sv
exe_wb_ctrl.sv
exe_unit.sv
tb_exe_unit.sv

/* Bender.yml */
package:
  name: exe_unit

sources:
  - include_dirs:
      - .
    files:
      - exe_unit_pkg.sv
      - prefix_adder.sv
      - barrel_shifter.sv
      - alu.sv
      - exe_datapath.sv
      - exe_wb_ctrl.sv
      - exe_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exe_unit.sv

/* tb_exe_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "exe_unit_defs.svh"

module tb_exe_unit import exe_unit_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int TOTAL_OPS   = 300;
    localparam int NUM_RANDOM  = 239;
    // ten bus transfers per op at two cycles each plus a margin
    localparam int WATCHDOG_NS = TOTAL_OPS * 10 * 2 * CLK_PERIOD + 12000;
    localparam int ACK_LIMIT   = 16;

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    reg_addr_t  wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;
    int         seed;
    int         op_count;
    word_t      corners [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

    exe_unit exe_unit_inst (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_adr   (wb_adr),
        .i_wb_dat   (wb_dat_w),
        .o_wb_dat   (wb_dat_r),
        .o_wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout: the test did not complete in the expected time");
    end

    // ack is a one cycle pulse and always answers a request
    assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else abort_run("ack stayed high for two cycles in a row");
    assert property (@(posedge clk) disable iff (rst) wb_ack |-> $past(wb_cyc && wb_stb))
        else abort_run("ack came without a bus request");

    function automatic word_t next_random();
        return $random(seed);
    endfunction

    task automatic wb_transfer(input logic we, input reg_addr_t adr, input word_t dat,
                               output word_t rdata);
        int waited;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            abort_run("timeout: the DUT never acked a bus transfer");
        end else begin
            assert (waited == 1)
                else abort_run($sformatf("error at %0t ns: ack after %0d cycles, expected 1",
                                         $time, waited));
            rdata  = wb_dat_r;
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic wb_write(input reg_addr_t adr, input word_t dat);
        word_t unused;
        wb_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input reg_addr_t adr, output word_t dat);
        wb_transfer(1'b0, adr, '0, dat);
    endtask

    task automatic check_read(input reg_addr_t adr, input word_t exp, input string what);
        word_t got;
        wb_read(adr, got);
        assert (got === exp)
            else abort_run($sformatf("error at %0t ns: %s read %h, expected %h",
                                     $time, what, got, exp));
    endtask

    // expected result and flags from the instruction rules
    function automatic void model_alu(input word_t a, input word_t b, input logic [5:0] ctrl,
                                      output word_t result, output flags_t flags);
        logic [3:0]     op;
        logic           sub;
        word_t          b_eff;
        logic [32:0]    usum;
        logic [32:0]    ssum;
        op      = ctrl[3:0];
        sub     = ctrl[4] || op == `OP_SLT || op == `OP_SLTU;
        b_eff   = sub ? ~b : b;
        usum    = {1'b0, a} + {1'b0, b_eff} + 33'(sub);
        // overflow when the top two bits of the sign extended sum disagree
        ssum    = {a[31], a} + {b_eff[31], b_eff} + 33'(sub);
        flags.n = usum[31];
        flags.z = (usum[31:0] == 32'd0);
        flags.c = usum[32];
        flags.v = ssum[32] ^ ssum[31];
        case (op)
            `OP_ADD:  result = usum[31:0];
            `OP_AND:  result = a & b;
            `OP_OR:   result = a | b;
            `OP_XOR:  result = a ^ b;
            `OP_SLL:  result = a << b[4:0];
            `OP_SRL:  result = a >> b[4:0];
            `OP_SRA:  result = $signed(a) >>> b[4:0];
            `OP_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `OP_SLTU: result = (a < b) ? 32'd1 : 32'd0;
            default:  result = 32'd0;
        endcase
    endfunction

    task automatic run_op(input word_t rs1, input word_t rs2, input word_t imm, input word_t pc,
                          input logic src, input logic sub, input logic [3:0] op);
        word_t  ctrl;
        word_t  exp_result;
        word_t  exp_branch;
        flags_t exp_flags;
        ctrl       = {26'd0, src, sub, op};
        exp_branch = pc + (imm << 1);
        model_alu(rs1, src ? imm : rs2, ctrl[5:0], exp_result, exp_flags);
        wb_write(`REG_RS1, rs1);
        wb_write(`REG_RS2, rs2);
        wb_write(`REG_IMM, imm);
        wb_write(`REG_PC, pc);
        wb_write(`REG_CTRL, ctrl);
        check_read(`REG_RESULT, exp_result, $sformatf("result of op %0d", op));
        check_read(`REG_BRANCH, exp_branch, "branch target");
        check_read(`REG_FLAGS, {28'd0, exp_flags}, $sformatf("flags of op %0d", op));
        check_read(`REG_CTRL, ctrl, "control word");
        // one operand register is read back per op in rotation
        case (op_count % 4)
            0:       check_read(`REG_RS1, rs1, "rs1");
            1:       check_read(`REG_RS2, rs2, "rs2");
            2:       check_read(`REG_IMM, imm, "imm");
            default: check_read(`REG_PC, pc, "pc");
        endcase
        op_count++;
    endtask

    initial begin
        seed     = 32'h568c13e0;
        op_count = 0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (wb_ack === 1'b0)
            else abort_run("ack was high right after reset");
        check_read(`REG_RESULT, '0, "result after reset");
        check_read(`REG_BRANCH, '0, "branch after reset");
        check_read(`REG_FLAGS, '0, "flags after reset");

        // add and subtract over the corner operands
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                run_op(corners[i], corners[j], next_random(), next_random(), 1'b0, 1'b0, `OP_ADD);
                run_op(corners[i], corners[j], next_random(), next_random(), 1'b0, 1'b1, `OP_ADD);
            end
        end

        // shift by 0 and 31 from rs2 and then from the immediate with a negative rs1
        for (int op = `OP_SLL; op <= `OP_SRA; op++) begin
            for (int sh = 0; sh <= 31; sh += 31) begin
                run_op(next_random(), sh, next_random(), next_random(), 1'b0, 1'b0, 4'(op));
                run_op(32'h8000_0001 | next_random(), next_random(), sh, next_random(),
                       1'b1, 1'b0, 4'(op));
            end
        end

        for (int op = `OP_AND; op <= `OP_XOR; op++) begin
            run_op(next_random(), next_random(), next_random(), next_random(), 1'b0, 1'b0, 4'(op));
            run_op(next_random(), next_random(), next_random(), next_random(), 1'b1, 1'b0, 4'(op));
        end

        // compares with the sub bit clear
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                run_op(corners[i], corners[j], next_random(), next_random(), 1'b0, 1'b0, `OP_SLT);
                run_op(corners[i], corners[j], next_random(), next_random(), 1'b0, 1'b0, `OP_SLTU);
            end
        end

        for (int op = 9; op <= 15; op++) begin
            run_op(next_random(), next_random(), next_random(), next_random(),
                   1'(next_random()), 1'(next_random()), 4'(op));
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_op(next_random(), next_random(), next_random(), next_random(),
                   1'(next_random()), 1'(next_random()), 4'(next_random() & 15));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* exe_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_unit import exe_unit_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic       i_wb_cyc,
    input  wire logic       i_wb_stb,
    input  wire logic       i_wb_we,
    input  wire reg_addr_t  i_wb_adr,
    input  wire word_t      i_wb_dat,
    output word_t           o_wb_dat,
    output logic            o_wb_ack
);
    wb_req_t    wb_req;
    exe_op_t    exe_op;
    exe_res_t   exe_res;

    assign wb_req = '{cyc: i_wb_cyc, stb: i_wb_stb, we: i_wb_we,
                      adr: i_wb_adr, dat: i_wb_dat};

    exe_wb_ctrl ctrl_inst (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (wb_req),
        .o_ack      (o_wb_ack),
        .o_rdata    (o_wb_dat),
        .o_op       (exe_op),
        .i_res      (exe_res)
    );

    // purely combinational, results return in the same cycle
    exe_datapath datapath_inst (
        .i_op       (exe_op),
        .o_res      (exe_res)
    );

endmodule

`default_nettype wire

/* exe_wb_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "exe_unit_defs.svh"

module exe_wb_ctrl import exe_unit_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire wb_req_t    i_req,
    output logic            o_ack,
    output word_t           o_rdata,
    output exe_op_t         o_op,
    input  wire exe_res_t   i_res
);
    bus_state_t state;
    word_t      rs1_q;
    word_t      rs2_q;
    word_t      imm_q;
    word_t      pc_q;
    logic       alu_src_q;
    alu_ctrl_t  alu_ctrl_q;
    word_t      result_q;
    word_t      branch_q;
    flags_t     flags_q;
    logic       ctrl_wr_q;
    logic       req_seen;
    word_t      rd_mux;

    assign req_seen = (state == ST_IDLE) && i_req.cyc && i_req.stb;

    always_comb begin
        rd_mux = '0;
        case (i_req.adr)
            `REG_RS1:    rd_mux = rs1_q;
            `REG_RS2:    rd_mux = rs2_q;
            `REG_IMM:    rd_mux = imm_q;
            `REG_PC:     rd_mux = pc_q;
            `REG_CTRL: begin
                rd_mux[`CTRL_SRC_BIT]    = alu_src_q;
                rd_mux[`CTRL_SUB_BIT:0]  = alu_ctrl_q;
            end
            `REG_RESULT: rd_mux = result_q;
            `REG_BRANCH: rd_mux = branch_q;
            `REG_FLAGS:  rd_mux = {{(`XLEN-4){1'b0}}, flags_q};
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= ST_IDLE;
            rs1_q      <= '0;
            rs2_q      <= '0;
            imm_q      <= '0;
            pc_q       <= '0;
            alu_src_q  <= 1'b0;
            alu_ctrl_q <= '0;
            result_q   <= '0;
            branch_q   <= '0;
            flags_q    <= '0;
            ctrl_wr_q  <= 1'b0;
            o_rdata    <= '0;
        end else begin
            case (state)
                ST_IDLE: state <= req_seen ? ST_ACK : ST_IDLE;
                default: state <= ST_IDLE;
            endcase

            // read data is sampled here and held through the ack cycle
            if (req_seen) begin
                o_rdata <= rd_mux;
            end

            // result, branch and flags are read only
            if (req_seen && i_req.we) begin
                case (i_req.adr)
                    `REG_RS1: rs1_q <= i_req.dat;
                    `REG_RS2: rs2_q <= i_req.dat;
                    `REG_IMM: imm_q <= i_req.dat;
                    `REG_PC:  pc_q  <= i_req.dat;
                    `REG_CTRL: begin
                        alu_src_q  <= i_req.dat[`CTRL_SRC_BIT];
                        alu_ctrl_q <= i_req.dat[`CTRL_SUB_BIT:0];
                    end
                    default: ;
                endcase
            end

            ctrl_wr_q <= req_seen && i_req.we && (i_req.adr == `REG_CTRL);

            // datapath has settled on the new control during the ack cycle
            if (state == ST_ACK && ctrl_wr_q) begin
                result_q <= i_res.result;
                branch_q <= i_res.branch;
                flags_q  <= i_res.flags;
            end
        end
    end

    assign o_ack = (state == ST_ACK);

    assign o_op = '{rs1: rs1_q, rs2: rs2_q, imm: imm_q, pc: pc_q,
                    alu_src: alu_src_q, alu_ctrl: alu_ctrl_q};

    // single cycle ack pulse, so a held strobe is acked every other cycle
    assert property (@(posedge i_clk) disable iff (i_rst) o_ack |=> !o_ack)
        else $error("ack high two cycles running");

    // no ack unless the master requested one the cycle before
    assert property (@(posedge i_clk) disable iff (i_rst)
                     o_ack |-> $past(i_req.cyc && i_req.stb))
        else $error("ack without a preceding request");

endmodule

`default_nettype wire

/* exe_datapath.sv */
`timescale 1ns/100ps
`default_nettype none
`include "exe_unit_defs.svh"

module exe_datapath import exe_unit_pkg::*; (
    input  wire exe_op_t    i_op,
    output exe_res_t        o_res
);
    word_t  alu_b;
    word_t  imm_x2;
    word_t  alu_result;
    flags_t alu_flags;
    word_t  branch;

    // immediate replaces rs2 for I-type ops
    assign alu_b  = i_op.alu_src ? i_op.imm : i_op.rs2;
    assign imm_x2 = {i_op.imm[`XLEN-2:0], 1'b0};

    alu alu_inst (
        .i_a        (i_op.rs1),
        .i_b        (alu_b),
        .i_ctrl     (i_op.alu_ctrl),
        .o_result   (alu_result),
        .o_flags    (alu_flags)
    );

    // branch target adder, flags not needed here
    prefix_adder #(
        .WIDTH      (`XLEN)
    ) branch_adder_inst (
        .i_a        (i_op.pc),
        .i_b        (imm_x2),
        .i_cin      (1'b0),
        .o_sum      (branch),
        .o_flags    ()
    );

    assign o_res = '{result: alu_result, branch: branch, flags: alu_flags};

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "exe_unit_defs.svh"

module alu import exe_unit_pkg::*; (
    input  wire word_t      i_a,
    input  wire word_t      i_b,
    input  wire alu_ctrl_t  i_ctrl,
    output word_t           o_result,
    output flags_t          o_flags
);
    logic [`CTRL_SUB_BIT-1:0]   op;
    logic                       sub;
    word_t                      b_eff;
    word_t                      sum;
    word_t                      shifted;
    flags_t                     flags;

    assign op = i_ctrl[`CTRL_SUB_BIT-1:0];

    // compares always subtract, regardless of the sub bit
    assign sub   = i_ctrl[`CTRL_SUB_BIT] | (op == `OP_SLT) | (op == `OP_SLTU);
    assign b_eff = sub ? ~i_b : i_b;

    prefix_adder #(
        .WIDTH      (`XLEN)
    ) adder_inst (
        .i_a        (i_a),
        .i_b        (b_eff),
        .i_cin      (sub),
        .o_sum      (sum),
        .o_flags    (flags)
    );

    barrel_shifter shifter_inst (
        .i_data     (i_a),
        .i_shamt    (i_b[`SHAMT_W-1:0]),
        .i_left     (op == `OP_SLL),
        .i_arith    (op == `OP_SRA),
        .o_data     (shifted)
    );

    always_comb begin
        case (op)
            `OP_ADD:  o_result = sum;
            `OP_AND:  o_result = i_a & i_b;
            `OP_OR:   o_result = i_a | i_b;
            `OP_XOR:  o_result = i_a ^ i_b;
            `OP_SLL,
            `OP_SRL,
            `OP_SRA:  o_result = shifted;
            `OP_SLT:  o_result = {{(`XLEN-1){1'b0}}, flags.n ^ flags.v};
            // borrow means a below b
            `OP_SLTU: o_result = {{(`XLEN-1){1'b0}}, ~flags.c};
            default:  o_result = '0;
        endcase
    end

    assign o_flags = flags;

endmodule

`default_nettype wire

/* barrel_shifter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "exe_unit_defs.svh"

module barrel_shifter import exe_unit_pkg::*; (
    input  wire word_t  i_data,
    input  wire shamt_t i_shamt,
    input  wire logic   i_left,
    input  wire logic   i_arith,
    output word_t       o_data
);
    wire [`XLEN-1:0]                rev_in;
    wire [`XLEN-1:0]                rev_out;
    wire [`SHAMT_W:0][`XLEN-1:0]    stage;
    logic                           fill;

    // left shifts run through the same right-shift chain bit reversed
    for (genvar i = 0; i < `XLEN; i++) begin : g_rev
        assign rev_in[i]  = i_data[`XLEN-1-i];
        assign rev_out[i] = stage[`SHAMT_W][`XLEN-1-i];
    end

    assign fill     = i_arith & ~i_left & i_data[`XLEN-1];
    assign stage[0] = i_left ? rev_in : i_data;

    for (genvar k = 0; k < `SHAMT_W; k++) begin : g_stage
        localparam int DIST = 1 << k;
        assign stage[k+1] = i_shamt[k] ? {{DIST{fill}}, stage[k][`XLEN-1:DIST]} : stage[k];
    end

    assign o_data = i_left ? rev_out : stage[`SHAMT_W];

endmodule

`default_nettype wire

/* prefix_adder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "exe_unit_defs.svh"

module prefix_adder import exe_unit_pkg::*; #(
    parameter int WIDTH = `XLEN
) (
    input  wire logic [WIDTH-1:0]   i_a,
    input  wire logic [WIDTH-1:0]   i_b,
    input  wire logic               i_cin,
    output logic [WIDTH-1:0]        o_sum,
    output flags_t                  o_flags
);
    localparam int STAGES = $clog2(WIDTH);

    wire [WIDTH-1:0]                prop;
    wire [STAGES:0][WIDTH-1:0]      g_lvl;
    // group propagate is not needed after the last stage
    wire [STAGES-1:0][WIDTH-1:0]    p_lvl;
    wire [WIDTH-1:0]                carry;

    assign prop     = i_a ^ i_b;
    assign p_lvl[0] = prop;

    // fold the carry-in into bit 0 so the tree yields true carries
    assign g_lvl[0] = (i_a & i_b) | {{(WIDTH-1){1'b0}}, prop[0] & i_cin};

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        localparam int DIST = 1 << s;
        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i >= DIST) begin : g_comb
                assign g_lvl[s+1][i] = g_lvl[s][i] | (p_lvl[s][i] & g_lvl[s][i-DIST]);
                if (s + 1 < STAGES) begin : g_prop
                    assign p_lvl[s+1][i] = p_lvl[s][i] & p_lvl[s][i-DIST];
                end
            end else begin : g_pass
                assign g_lvl[s+1][i] = g_lvl[s][i];
                if (s + 1 < STAGES) begin : g_prop
                    assign p_lvl[s+1][i] = p_lvl[s][i];
                end
            end
        end
    end

    // carry out of each bit position
    assign carry = g_lvl[STAGES];

    assign o_sum = prop ^ {carry[WIDTH-2:0], i_cin};

    assign o_flags.n = o_sum[WIDTH-1];
    assign o_flags.z = ~|o_sum;
    assign o_flags.c = carry[WIDTH-1];
    // signed overflow when carry into and out of the msb differ
    assign o_flags.v = carry[WIDTH-1] ^ carry[WIDTH-2];

endmodule

`default_nettype wire

/* exe_unit_pkg.sv */
`default_nettype none
`include "exe_unit_defs.svh"

package exe_unit_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`SHAMT_W-1:0]    shamt_t;

    // subtract on the top bit, op code below it
    typedef logic [`CTRL_SUB_BIT:0] alu_ctrl_t;

    typedef logic [2:0]             reg_addr_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        reg_addr_t  adr;
        word_t      dat;
    } wb_req_t;

    // operands and control as seen by the execute datapath
    typedef struct packed {
        word_t      rs1;
        word_t      rs2;
        word_t      imm;
        word_t      pc;
        logic       alu_src;
        alu_ctrl_t  alu_ctrl;
    } exe_op_t;

    typedef struct packed {
        word_t      result;
        word_t      branch;
        flags_t     flags;
    } exe_res_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } bus_state_t;

endpackage

`default_nettype wire

/* exe_unit_defs.svh */
`ifndef EXE_UNIT_DEFS_SVH
`define EXE_UNIT_DEFS_SVH

// datapath widths
`define XLEN            32
`define SHAMT_W         5

// register map, word offsets on adr[4:2]
`define REG_RS1         3'd0
`define REG_RS2         3'd1
`define REG_IMM         3'd2
`define REG_PC          3'd3
`define REG_CTRL        3'd4
`define REG_RESULT      3'd5
`define REG_BRANCH      3'd6
`define REG_FLAGS       3'd7

// alu op codes on ctrl[3:0]
`define OP_ADD          4'd0
`define OP_AND          4'd1
`define OP_OR           4'd2
`define OP_XOR          4'd3
`define OP_SLL          4'd4
`define OP_SRL          4'd5
`define OP_SRA          4'd6
`define OP_SLT          4'd7
`define OP_SLTU         4'd8

// control word layout
`define CTRL_SUB_BIT    4
`define CTRL_SRC_BIT    5

`endif
